/* source/core_pkg.sv */
package core_pkg;

    // Machine widths
    localparam int ISSUE_WIDTH = 2;
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ORDER_W = 64;
    localparam int SHAMT_W = $clog2(XLEN);
    localparam int NUM_REGS = 1 << REG_ADDR_W;
    // Two source reads per slot
    localparam int RF_READ_PORTS = 2 * ISSUE_WIDTH;

    // Major opcodes handled by this slice
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    // Integer funct3 encodings
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // LUI passes the U immediate straight through
        ALU_PASS_B
    } alu_op_e;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // Register-immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_type_t;

    // Same 32 bits seen as R or I format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic use_imm;
        logic [XLEN-1:0] imm;
        alu_op_e alu_op;
        logic writes_rd;
    } decoded_inst_t;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [REG_ADDR_W-1:0] rd;
        logic writes_rd;
        logic [XLEN-1:0] value;
    } exec_result_t;

    // One slot of the retirement trace
    typedef struct packed {
        logic valid;
        logic [ORDER_W-1:0] order;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0] rd_wdata;
    } commit_slot_t;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps

module alu
import core_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y
);

    // Shifts use only the low bits of b
    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_SLL: y = a << shamt;
            // Compare results are zero-extended flags
            ALU_SLT: y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR: y = a ^ b;
            ALU_SRL: y = a >> shamt;
            ALU_SRA: y = $unsigned($signed(a) >>> shamt);
            ALU_OR: y = a | b;
            ALU_AND: y = a & b;
            ALU_PASS_B: y = b;
            default: y = '0;
        endcase
    end

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
import core_pkg::*;
(
    input  inst_word_u      inst,
    input  logic [XLEN-1:0] pc,
    output decoded_inst_t   slot
);

    // Cleared for opcodes this slice does not execute
    logic supported;

    // Shared funct3 map, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL: op = ALU_SLL;
            F3_SLT: op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR: op = ALU_XOR;
            F3_SR: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        supported = 1'b1;
        slot.inst = inst;
        slot.pc = pc;
        // Register fields sit at the same bits in every format
        slot.rs1 = inst.r.rs1;
        slot.rs2 = inst.r.rs2;
        slot.rd = inst.r.rd;
        slot.use_imm = 1'b0;
        // Sign-extended I immediate by default
        slot.imm = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
        slot.alu_op = ALU_ADD;
        case (inst.r.opcode)
            OPC_OP: begin
                // funct7 bit 5 selects SUB and SRA
                slot.alu_op = alu_from_funct3(inst.r.funct3, inst.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                slot.use_imm = 1'b1;
                // Only SRAI borrows imm bit 10, ADDI has no subtract form
                slot.alu_op = alu_from_funct3(inst.i.funct3,
                    (inst.i.funct3 == F3_SR) && inst.i.imm12[10]);
            end
            OPC_LUI: begin
                slot.use_imm = 1'b1;
                // Upper 20 bits rebuilt from the I view
                slot.imm = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
                slot.alu_op = ALU_PASS_B;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        // x0 destination never writes
        slot.writes_rd = supported && (inst.r.rd != '0);
    end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [XLEN-1:0]             in_pc,
    input  logic [ISSUE_WIDTH*XLEN-1:0] in_inst,
    output logic                        dec_valid,
    output decoded_inst_t               dec_pair [ISSUE_WIDTH]
);

    inst_word_u slot_word [ISSUE_WIDTH];
    logic [XLEN-1:0] slot_pc [ISSUE_WIDTH];
    decoded_inst_t dec_next [ISSUE_WIDTH];

    // One decoder per slot, slot 0 in the low word
    generate
        for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
            assign slot_word[i] = in_inst[XLEN*i +: XLEN];
            // Consecutive words, four bytes apart
            assign slot_pc[i] = in_pc + XLEN'(4 * i);

            inst_decoder i_dec (
                .inst(slot_word[i]),
                .pc  (slot_pc[i]),
                .slot(dec_next[i])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Decoded pair only loads on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_pair <= dec_next;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file
import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rd_addr [RF_READ_PORTS],
    output logic [XLEN-1:0]       rd_data [RF_READ_PORTS],
    input  logic                  we      [ISSUE_WIDTH],
    input  logic [REG_ADDR_W-1:0] wr_addr [ISSUE_WIDTH],
    input  logic [XLEN-1:0]       wr_data [ISSUE_WIDTH]
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later slot overrides an earlier one to the same register
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (we[s] && (wr_addr[s] != '0)) begin
                    regs[wr_addr[s]] <= wr_data[s];
                end
            end
        end
    end

    // Reads return state from earlier edges only
    always_comb begin
        for (int p = 0; p < RF_READ_PORTS; p++) begin
            rd_data[p] = (rd_addr[p] == '0) ? '0 : regs[rd_addr[p]];
        end
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  decoded_inst_t         dec_pair [ISSUE_WIDTH],
    output logic [REG_ADDR_W-1:0] rf_addr  [RF_READ_PORTS],
    input  logic [XLEN-1:0]       rf_data  [RF_READ_PORTS],
    output logic                  ex_valid,
    output exec_result_t          ex_pair  [ISSUE_WIDTH]
);

    // Source values after forwarding from the result stage
    logic [XLEN-1:0] fwd_a [ISSUE_WIDTH];
    logic [XLEN-1:0] fwd_b [ISSUE_WIDTH];
    // ALU operands and results per slot
    logic [XLEN-1:0] slot0_a, slot0_b, slot0_y;
    logic [XLEN-1:0] slot1_a, slot1_rs2, slot1_b, slot1_y;
    exec_result_t ex_next [ISSUE_WIDTH];

    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            // Ports 2s and 2s+1 serve rs1 and rs2 of slot s
            rf_addr[2*s] = dec_pair[s].rs1;
            rf_addr[2*s+1] = dec_pair[s].rs2;
            fwd_a[s] = rf_data[2*s];
            fwd_b[s] = rf_data[2*s+1];
            // Older pair writes at the next edge, ascending order lets slot 1 win
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (ex_valid && ex_pair[p].writes_rd) begin
                    if (ex_pair[p].rd == dec_pair[s].rs1) begin
                        fwd_a[s] = ex_pair[p].value;
                    end
                    if (ex_pair[p].rd == dec_pair[s].rs2) begin
                        fwd_b[s] = ex_pair[p].value;
                    end
                end
            end
        end
    end

    // Slot 0 sees only forwarded register values
    assign slot0_a = fwd_a[0];
    assign slot0_b = dec_pair[0].use_imm ? dec_pair[0].imm : fwd_b[0];

    // Slot 1 bypass from slot 0 result, newest value
    always_comb begin
        slot1_a = fwd_a[1];
        slot1_rs2 = fwd_b[1];
        if (dec_pair[0].writes_rd) begin
            if (dec_pair[0].rd == dec_pair[1].rs1) begin
                slot1_a = slot0_y;
            end
            if (dec_pair[0].rd == dec_pair[1].rs2) begin
                slot1_rs2 = slot0_y;
            end
        end
        slot1_b = dec_pair[1].use_imm ? dec_pair[1].imm : slot1_rs2;
    end

    alu i_alu0 (
        .op(dec_pair[0].alu_op),
        .a (slot0_a),
        .b (slot0_b),
        .y (slot0_y)
    );

    alu i_alu1 (
        .op(dec_pair[1].alu_op),
        .a (slot1_a),
        .b (slot1_b),
        .y (slot1_y)
    );

    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            ex_next[s].inst = dec_pair[s].inst;
            ex_next[s].pc = dec_pair[s].pc;
            ex_next[s].rd = dec_pair[s].rd;
            ex_next[s].writes_rd = dec_pair[s].writes_rd;
        end
        ex_next[0].value = slot0_y;
        ex_next[1].value = slot1_y;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    // Results and metadata held for the result stage
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_pair <= ex_next;
        end
    end

endmodule

/* source/result_stage.sv */
`timescale 1ns/1ps

module result_stage
import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  exec_result_t          ex_pair [ISSUE_WIDTH],
    output logic                  we      [ISSUE_WIDTH],
    output logic [REG_ADDR_W-1:0] wr_addr [ISSUE_WIDTH],
    output logic [XLEN-1:0]       wr_data [ISSUE_WIDTH],
    output commit_slot_t          commit  [ISSUE_WIDTH]
);

    // Order of the next slot 0 to retire
    logic [ORDER_W-1:0] order_q;

    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            // Register file write ports
            we[s] = ex_valid && ex_pair[s].writes_rd;
            wr_addr[s] = ex_pair[s].rd;
            wr_data[s] = ex_pair[s].value;

            // Trace slot, all zero when idle
            commit[s] = '0;
            if (ex_valid) begin
                commit[s].valid = 1'b1;
                commit[s].order = order_q + ORDER_W'(s);
                commit[s].inst = ex_pair[s].inst;
                commit[s].pc = ex_pair[s].pc;
                // No register write shows as x0 with zero data
                if (ex_pair[s].writes_rd) begin
                    commit[s].rd_addr = ex_pair[s].rd;
                    commit[s].rd_wdata = ex_pair[s].value;
                end
            end
        end
    end

    // Advances by the pair width per retired pair
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (ex_valid) begin
            order_q <= order_q + ORDER_W'(ISSUE_WIDTH);
        end
    end

endmodule

/* source/dual_issue_core.sv */
`timescale 1ns/1ps

module dual_issue_core
import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [XLEN-1:0]             in_pc,
    input  logic [ISSUE_WIDTH*XLEN-1:0] in_inst,
    output commit_slot_t                commit [ISSUE_WIDTH]
);

    // Decode to execute
    logic dec_valid;
    decoded_inst_t dec_pair [ISSUE_WIDTH];

    // Execute to register file reads
    logic [REG_ADDR_W-1:0] rf_addr [RF_READ_PORTS];
    logic [XLEN-1:0] rf_data [RF_READ_PORTS];

    // Execute to result
    logic ex_valid;
    exec_result_t ex_pair [ISSUE_WIDTH];

    // Result to register file writes
    logic we [ISSUE_WIDTH];
    logic [REG_ADDR_W-1:0] wr_addr [ISSUE_WIDTH];
    logic [XLEN-1:0] wr_data [ISSUE_WIDTH];

    decode_stage i_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .dec_valid(dec_valid),
        .dec_pair (dec_pair)
    );

    execute_stage i_execute (
        .clk      (clk),
        .rst      (rst),
        .dec_valid(dec_valid),
        .dec_pair (dec_pair),
        .rf_addr  (rf_addr),
        .rf_data  (rf_data),
        .ex_valid (ex_valid),
        .ex_pair  (ex_pair)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .rst    (rst),
        .rd_addr(rf_addr),
        .rd_data(rf_data),
        .we     (we),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    result_stage i_result (
        .clk     (clk),
        .rst     (rst),
        .ex_valid(ex_valid),
        .ex_pair (ex_pair),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .commit  (commit)
    );

endmodule

/* verif/tb_core.sv */
`timescale 1ns/1ps

module tb_core
import core_pkg::*;
;

    // Cycles allowed for queued pairs to retire
    localparam int DRAIN_LIMIT = 20;

    // One sent pair and the cycle its commit is due
    typedef struct packed {
        logic [31:0] due;
        commit_slot_t [ISSUE_WIDTH-1:0] slots;
    } expected_pair_t;

    logic clk = 1'b0;
    logic rst;
    logic in_valid;
    logic [XLEN-1:0] in_pc;
    logic [ISSUE_WIDTH*XLEN-1:0] in_inst;
    commit_slot_t commit [ISSUE_WIDTH];

    logic [31:0] cycle = '0;
    logic [31:0] rng_state = 32'h6e07711f;
    logic [31:0] next_pc = 32'h0000_1000;
    // Architectural state of the reference model
    logic [31:0] model_regs [32];
    logic [63:0] model_order = '0;
    expected_pair_t exp_q [$];

    int errors = 0;
    int test_start_errors = 0;
    int tests_run = 0;
    int tests_passed = 0;

    dual_issue_core i_dut (
        .clk     (clk),
        .rst     (rst),
        .in_valid(in_valid),
        .in_pc   (in_pc),
        .in_inst (in_inst),
        .commit  (commit)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {funct7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm12, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, 7'b0110111};
    endfunction

    // SW with its offset bits in the rd field
    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [4:0] off5);
        return {7'b0, rs2, rs1, 3'b010, off5, 7'b0100011};
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] a, input logic [31:0] b);
        logic [31:0] y;
        case (f3)
            3'b000: y = alt ? a - b : a + b;
            3'b001: y = a << b[4:0];
            3'b010: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: y = (a < b) ? 32'd1 : 32'd0;
            3'b100: y = a ^ b;
            3'b101: begin
                if (alt) begin
                    y = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    y = a >> b[4:0];
                end
            end
            3'b110: y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // Executes one word in program order and updates the model
    function automatic void retire_in_model(input logic [31:0] w, input logic [31:0] pc,
                                            output commit_slot_t exp);
        logic [4:0] rd;
        logic [2:0] f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic ok;
        rd = w[11:7];
        f3 = w[14:12];
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        val = '0;
        ok = 1'b1;
        case (w[6:0])
            7'b0110011: val = alu_reference(f3, w[30], a, b);
            // Only SRAI uses imm bit 10
            7'b0010011: val = alu_reference(f3, (f3 == 3'b101) && w[30], a,
                                            {{20{w[31]}}, w[31:20]});
            7'b0110111: val = {w[31:12], 12'b0};
            default: ok = 1'b0;
        endcase
        exp = '0;
        exp.valid = 1'b1;
        exp.order = model_order;
        exp.inst = w;
        exp.pc = pc;
        if (ok && (rd != 5'd0)) begin
            exp.rd_addr = rd;
            exp.rd_wdata = val;
            model_regs[rd] = val;
        end
        model_order = model_order + 64'd1;
    endfunction

    // Supported instruction on x0..x7 to force dependencies
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic alt;
        logic [11:0] imm;
        logic [31:0] word;
        r = next_rand();
        s = next_rand();
        rd = {2'b0, r[31:29]};
        rs1 = {2'b0, r[28:26]};
        rs2 = {2'b0, r[25:23]};
        f3 = r[22:20];
        alt = r[19];
        imm = s[31:20];
        case (r[18:17])
            2'd0: begin
                // funct7 0x20 only for SUB and SRA
                word = r_type_word((alt && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00,
                                   rs2, rs1, f3, rd);
            end
            2'd3: word = lui_word(s[31:12], rd);
            default: begin
                if (f3 == 3'b001) begin
                    imm = {7'h00, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                end
                word = i_type_word(imm, rs1, f3, rd);
            end
        endcase
        return word;
    endfunction

    function automatic void compare_field(input string name, input int s,
                                          input logic [63:0] expected, input logic [63:0] actual);
        assert (actual == expected) else begin
            $display("mismatch commit[%0d].%s: expected %h, got %h", s, name, expected, actual);
            errors++;
        end
    endfunction

    task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
        expected_pair_t entry;
        commit_slot_t e0;
        commit_slot_t e1;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_pc = next_pc;
        in_inst = {w1, w0};
        // Decode edge and execute edge before commit
        entry.due = cycle + 32'd2;
        retire_in_model(w0, next_pc, e0);
        retire_in_model(w1, next_pc + 32'd4, e1);
        entry.slots[0] = e0;
        entry.slots[1] = e1;
        exp_q.push_back(entry);
        next_pc = next_pc + 32'd8;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        idle_cycle();
        waited = 0;
        while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d pairs never retired within %0d cycles", exp_q.size(), waited);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        end
    endtask

    // Commit is combinational from registers and stable at the falling edge
    always @(negedge clk) begin : check_commit
        expected_pair_t head;
        head = '0;
        if (!rst) begin
            if ((exp_q.size() != 0) && (exp_q[0].due == cycle)) begin
                head = exp_q.pop_front();
            end
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                compare_field("valid", s, 64'(head.slots[s].valid), 64'(commit[s].valid));
                if (head.slots[s].valid && commit[s].valid) begin
                    compare_field("order", s, head.slots[s].order, commit[s].order);
                    compare_field("inst", s, 64'(head.slots[s].inst), 64'(commit[s].inst));
                    compare_field("pc", s, 64'(head.slots[s].pc), 64'(commit[s].pc));
                    compare_field("rd_addr", s, 64'(head.slots[s].rd_addr),
                                  64'(commit[s].rd_addr));
                    compare_field("rd_wdata", s, 64'(head.slots[s].rd_wdata),
                                  64'(commit[s].rd_wdata));
                end
            end
        end
    end

    initial begin : main
        logic [31:0] gap_word;
        rst = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        begin_test();
        repeat (5) idle_cycle();
        end_test("idle after reset");

        begin_test();
        // ADDI x1 = 5 then ADD x2 = x1 + x1
        send_pair(i_type_word(12'd5, 5'd0, 3'b000, 5'd1),
                  r_type_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        wait_drain();
        send_pair(lui_word(20'h12345, 5'd3), i_type_word(12'hfff, 5'd3, 3'b000, 5'd4));
        wait_drain();
        end_test("directed addi add lui");

        begin_test();
        send_pair(i_type_word(12'd100, 5'd0, 3'b000, 5'd5),
                  r_type_word(7'h20, 5'd1, 5'd5, 3'b000, 5'd6));
        // Both slots write x7 and slot 1 wins
        send_pair(i_type_word(12'd11, 5'd0, 3'b000, 5'd7),
                  i_type_word(12'd22, 5'd0, 3'b000, 5'd7));
        send_pair(r_type_word(7'h00, 5'd0, 5'd7, 3'b000, 5'd8),
                  r_type_word(7'h00, 5'd5, 5'd7, 3'b110, 5'd9));
        wait_drain();
        // Same reads again from the register file
        send_pair(r_type_word(7'h00, 5'd7, 5'd7, 3'b000, 5'd8),
                  r_type_word(7'h00, 5'd7, 5'd1, 3'b010, 5'd9));
        wait_drain();
        end_test("in-pair bypass and same rd");

        begin_test();
        send_pair(i_type_word(12'd3, 5'd0, 3'b000, 5'd10),
                  i_type_word(12'd7, 5'd0, 3'b000, 5'd11));
        for (int i = 0; i < 6; i++) begin
            send_pair(r_type_word(7'h00, 5'd11, 5'd10, 3'b000, 5'd10),
                      r_type_word(7'h00, 5'd11, 5'd10, 3'b100, 5'd11));
        end
        send_pair(r_type_word(7'h00, 5'd1, 5'd10, 3'b001, 5'd12),
                  r_type_word(7'h20, 5'd1, 5'd12, 3'b101, 5'd13));
        wait_drain();
        end_test("back-to-back forwarding");

        begin_test();
        // SW with offset 4 in the rd field then ADDI to x0
        send_pair(store_word(5'd5, 5'd1, 5'd4), i_type_word(12'd9, 5'd1, 3'b000, 5'd0));
        send_pair(r_type_word(7'h00, 5'd0, 5'd4, 3'b000, 5'd13),
                  r_type_word(7'h00, 5'd0, 5'd1, 3'b000, 5'd14));
        // JAL to x3 and ADD to x0
        send_pair({20'h00100, 5'd3, 7'b1101111}, r_type_word(7'h00, 5'd2, 5'd2, 3'b000, 5'd0));
        wait_drain();
        send_pair(r_type_word(7'h00, 5'd0, 5'd3, 3'b000, 5'd15),
                  r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd16));
        wait_drain();
        end_test("unsupported and x0 writes");

        begin_test();
        for (int n = 0; n < 200; n++) begin
            send_pair(random_inst(), random_inst());
            gap_word = next_rand();
            // Zero to three idle cycles between strobes
            repeat (gap_word[31:30]) idle_cycle();
        end
        wait_drain();
        end_test("random pairs");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* compile.f */
source/core_pkg.sv
source/alu.sv
source/inst_decoder.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/result_stage.sv
source/dual_issue_core.sv
verif/tb_core.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = tb_core
FILELIST = compile.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_TEXT = FAIL: see errors above
SOURCES = $(wildcard source/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
